// File: list.f
rtl/icache_pkg.sv
rtl/icache_fill_if.sv
rtl/icache_array.sv
rtl/icache_refill.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
tests/tb_mem_model.sv
tests/tb_icache.sv

// File: rtl/icache_array.sv
`timescale 1ns/1ps

module icache_array
	import icache_pkg::*;
(
	input  logic               clk,
	input  logic               rst_n,
	input  fetch_addr_u        lookup_addr,
	input  logic               touch,
	icache_fill_if.array       fill,
	output logic               hit,
	output logic [data_w-1:0]  hit_word,
	output logic               victim_way
);

	logic [tag_w-1:0]   tag_mem  [2][num_sets];
	logic [data_w-1:0]  data_mem [2][num_sets][beats_per_line];
	logic [num_sets-1:0] valid_q [2];
	logic [num_sets-1:0] lru_q;  // way to evict when both valid

	logic [index_w-1:0] idx;
	logic               hit0;
	logic               hit1;
	logic               set_v0;
	logic               set_v1;

	assign idx    = lookup_addr.f.index;
	assign set_v0 = valid_q[0][idx];
	assign set_v1 = valid_q[1][idx];

	// tag compare on both ways at once
	assign hit0 = set_v0 && (tag_mem[0][idx] == lookup_addr.f.tag);
	assign hit1 = set_v1 && (tag_mem[1][idx] == lookup_addr.f.tag);
	assign hit  = hit0 || hit1;

	always_comb begin
		if (hit1) begin
			hit_word = data_mem[1][idx][lookup_addr.f.word];
		end else begin
			hit_word = data_mem[0][idx][lookup_addr.f.word];
		end
	end

	// empty way first, way 0 before way 1, else lru
	always_comb begin
		if (!set_v0) begin
			victim_way = 1'b0;
		end else if (!set_v1) begin
			victim_way = 1'b1;
		end else begin
			victim_way = lru_q[idx];
		end
	end

	// line payload, written beat by beat
	always_ff @(posedge clk) begin
		if (fill.we) begin
			data_mem[fill.way][fill.index][fill.beat] <= fill.data;
			if (fill.last) begin
				tag_mem[fill.way][fill.index] <= fill.tag;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q[0] <= '0;
			valid_q[1] <= '0;
			lru_q      <= '0;
		end else if (fill.we && fill.last) begin
			valid_q[fill.way][fill.index] <= 1'b1;
			lru_q[fill.index]             <= ~fill.way; // fresh line is mru
		end else if (touch) begin
			lru_q[idx] <= ~hit1;
		end
	end

endmodule

// File: rtl/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl
	import icache_pkg::*;
(
	input  logic               clk,
	input  logic               rst_n,
	input  logic               cpu_req_valid,
	input  logic [addr_w-1:0]  cpu_req_addr,
	input  logic               hit,
	input  logic [data_w-1:0]  hit_word,
	input  logic               victim_way,
	input  logic               fill_done,
	output logic               cpu_ready,
	output logic [data_w-1:0]  cpu_data_read,
	output fetch_addr_u        lookup_addr,
	output logic               touch,
	output logic               fill_start,
	output logic               fill_way,
	output fetch_addr_u        fill_addr
);

	ctrl_state_e state_q;
	ctrl_state_e state_d;
	fetch_addr_u addr_q;   // request held for the whole transaction
	logic        accept;
	logic        miss;

	assign accept = (state_q == st_idle) && cpu_req_valid;
	assign touch  = (state_q == st_compare) && hit;
	assign miss   = (state_q == st_compare) && !hit;

	assign lookup_addr = addr_q;
	assign fill_addr   = addr_q;

	always_comb begin
		state_d = state_q;
		case (state_q)
			st_idle: begin
				if (cpu_req_valid) begin
					state_d = st_compare;
				end
			end
			st_compare: begin
				if (hit) begin
					state_d = st_idle;
				end else begin
					state_d = st_allocate;
				end
			end
			st_allocate: begin
				if (fill_done) begin
					state_d = st_compare; // retry the lookup, it hits now
				end
			end
			default: state_d = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			addr_q.raw <= cpu_req_addr;
		end
		if (touch) begin
			cpu_data_read <= hit_word;
		end
		if (miss) begin
			fill_way <= victim_way;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q    <= st_idle;
			cpu_ready  <= 1'b0;
			fill_start <= 1'b0;
		end else begin
			state_q    <= state_d;
			cpu_ready  <= touch;  // single-cycle reply
			fill_start <= miss;
		end
	end

endmodule

// File: rtl/icache_fill_if.sv
`timescale 1ns/1ps

interface icache_fill_if
	import icache_pkg::*;
();

	logic                  we;    // one beat written this cycle
	logic [index_w-1:0]    index;
	logic                  way;
	logic [beat_w-1:0]     beat;  // word slot inside the line
	logic [data_w-1:0]     data;
	logic [tag_w-1:0]      tag;
	logic                  last;  // final beat, line becomes valid

	modport refill (
		output we, index, way, beat, data, tag, last
	);

	modport array (
		input we, index, way, beat, data, tag, last
	);

endinterface

// File: rtl/icache_pkg.sv
package icache_pkg;

	// cache geometry
	localparam int addr_w         = 64;
	localparam int data_w         = 64;
	localparam int num_sets       = 64;
	localparam int index_w        = 6;
	localparam int offset_w       = 5;   // 32-byte lines
	localparam int tag_w          = addr_w - index_w - offset_w;
	localparam int beats_per_line = 4;
	localparam int beat_w         = 2;
	localparam int byte_off_w     = offset_w - beat_w; // byte within a 64-bit word

	// fetch address seen as one word or as its cache fields
	typedef struct packed {
		logic [tag_w-1:0]      tag;
		logic [index_w-1:0]    index;
		logic [beat_w-1:0]     word;
		logic [byte_off_w-1:0] byte_off;
	} fetch_fields_t;

	typedef union packed {
		logic [addr_w-1:0] raw;
		fetch_fields_t     f;
	} fetch_addr_u;

	// controller states
	typedef enum logic [1:0] {
		st_idle,
		st_compare,
		st_allocate
	} ctrl_state_e;

endpackage

// File: rtl/icache_refill.sv
`timescale 1ns/1ps

module icache_refill
	import icache_pkg::*;
(
	input  logic               clk,
	input  logic               rst_n,
	input  logic               fill_start,
	input  logic               fill_way,
	input  fetch_addr_u        fill_addr,
	input  logic               mem_ready,
	input  logic [data_w-1:0]  mem_data_read,
	output logic               mem_req_valid,
	output logic [addr_w-1:0]  mem_req_addr,
	output logic               fill_done,
	icache_fill_if.refill      fill
);

	logic              busy_q;
	logic [beat_w-1:0] beat_q;
	logic              way_q;
	fetch_addr_u       line_q;  // line-aligned copy of the miss address
	logic              beat_ok;
	logic              last_beat;

	assign beat_ok   = busy_q && mem_ready;
	assign last_beat = (beat_q == beat_w'(beats_per_line - 1));

	assign mem_req_valid = busy_q;
	assign mem_req_addr  = line_q.raw;

	// each accepted beat goes straight into the array
	assign fill.we    = beat_ok;
	assign fill.index = line_q.f.index;
	assign fill.way   = way_q;
	assign fill.beat  = beat_q;
	assign fill.data  = mem_data_read;
	assign fill.tag   = line_q.f.tag;
	assign fill.last  = beat_ok && last_beat;

	always_ff @(posedge clk) begin
		if (fill_start) begin
			line_q.raw <= {fill_addr.raw[addr_w-1:offset_w], offset_w'(0)};
			way_q      <= fill_way;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy_q    <= 1'b0;
			beat_q    <= '0;
			fill_done <= 1'b0;
		end else begin
			fill_done <= 1'b0;
			if (fill_start) begin
				busy_q <= 1'b1;
				beat_q <= '0;
			end else if (beat_ok) begin
				beat_q <= beat_q + 1'b1;
				if (last_beat) begin
					busy_q    <= 1'b0; // request drops with the fourth beat
					fill_done <= 1'b1;
				end
			end
		end
	end

endmodule

// File: rtl/icache_top.sv
`timescale 1ns/1ps

module icache_top
	import icache_pkg::*;
(
	input  logic               clk,
	input  logic               rst_n,
	input  logic               cpu_req_valid,
	input  logic [addr_w-1:0]  cpu_req_addr,
	input  logic               mem_ready,
	input  logic [data_w-1:0]  mem_data_read,
	output logic [data_w-1:0]  cpu_data_read,
	output logic               cpu_ready,
	output logic [addr_w-1:0]  mem_req_addr,
	output logic               mem_req_valid
);

	fetch_addr_u       lookup_addr;
	fetch_addr_u       fill_addr;
	logic              hit;
	logic [data_w-1:0] hit_word;
	logic              victim_way;
	logic              touch;
	logic              fill_start;
	logic              fill_way;
	logic              fill_done;

	icache_fill_if fill_bus ();

	icache_ctrl u_ctrl (
		.clk           (clk),
		.rst_n         (rst_n),
		.cpu_req_valid (cpu_req_valid),
		.cpu_req_addr  (cpu_req_addr),
		.hit           (hit),
		.hit_word      (hit_word),
		.victim_way    (victim_way),
		.fill_done     (fill_done),
		.cpu_ready     (cpu_ready),
		.cpu_data_read (cpu_data_read),
		.lookup_addr   (lookup_addr),
		.touch         (touch),
		.fill_start    (fill_start),
		.fill_way      (fill_way),
		.fill_addr     (fill_addr)
	);

	icache_array u_array (
		.clk         (clk),
		.rst_n       (rst_n),
		.lookup_addr (lookup_addr),
		.touch       (touch),
		.fill        (fill_bus.array),
		.hit         (hit),
		.hit_word    (hit_word),
		.victim_way  (victim_way)
	);

	icache_refill u_refill (
		.clk           (clk),
		.rst_n         (rst_n),
		.fill_start    (fill_start),
		.fill_way      (fill_way),
		.fill_addr     (fill_addr),
		.mem_ready     (mem_ready),
		.mem_data_read (mem_data_read),
		.mem_req_valid (mem_req_valid),
		.mem_req_addr  (mem_req_addr),
		.fill_done     (fill_done),
		.fill          (fill_bus.refill)
	);

endmodule

// File: tests/tb_icache.sv
`timescale 1ns/1ps

module tb_icache
	import icache_pkg::*;
();

	localparam int n_rows = 18;

	typedef struct packed {
		logic [addr_w-1:0] addr;
		logic              rst_before; // reset pulse ahead of this fetch
		logic              exp_hit;
		logic [7:0]        exp_reqs;   // line requests seen after this row
	} row_t;

	logic              clk = 1'b0;
	logic              rst_n;
	logic              cpu_req_valid;
	logic [addr_w-1:0] cpu_req_addr;
	logic              mem_ready;
	logic [data_w-1:0] mem_data_read;
	logic [data_w-1:0] cpu_data_read;
	logic              cpu_ready;
	logic [addr_w-1:0] mem_req_addr;
	logic              mem_req_valid;
	int                req_count;
	logic [addr_w-1:0] last_req_addr;
	row_t              tbl [n_rows];
	int                errors;
	int                checks;

	icache_top u_dut (
		.clk           (clk),
		.rst_n         (rst_n),
		.cpu_req_valid (cpu_req_valid),
		.cpu_req_addr  (cpu_req_addr),
		.mem_ready     (mem_ready),
		.mem_data_read (mem_data_read),
		.cpu_data_read (cpu_data_read),
		.cpu_ready     (cpu_ready),
		.mem_req_addr  (mem_req_addr),
		.mem_req_valid (mem_req_valid)
	);

	tb_mem_model u_mem (
		.clk           (clk),
		.rst_n         (rst_n),
		.mem_req_valid (mem_req_valid),
		.mem_req_addr  (mem_req_addr),
		.mem_ready     (mem_ready),
		.mem_data_read (mem_data_read),
		.req_count     (req_count),
		.last_req_addr (last_req_addr)
	);

	initial begin
		forever #4 clk = ~clk;
	end

	initial begin
		repeat (n_rows * 40 + 50) @(posedge clk);
		$display("Timeout: the cache stopped answering fetch requests");
		$display("Something failed");
		$finish;
	end

	// word the memory rule gives for any byte address
	function automatic logic [data_w-1:0] expected_word(input fetch_addr_u a);
		logic [31:0] v;
		v = {a.raw[31:offset_w], offset_w'(0)} + 32'({a.f.word, 3'b000});
		return {v, ~v};
	endfunction

	// set 5 holds lines A 0x..08A0, B 0x..10A0, C 0x..18A0; D sits in set 63
	task load_table();
		tbl[0]  = {64'h0000_0012_3400_08B8, 1'b0, 1'b0, 8'd1}; // A word 3, cold miss
		tbl[1]  = {64'h0000_0012_3400_08A0, 1'b0, 1'b1, 8'd1};
		tbl[2]  = {64'h0000_0012_3400_08A8, 1'b0, 1'b1, 8'd1};
		tbl[3]  = {64'h0000_0012_3400_08B4, 1'b0, 1'b1, 8'd1};
		tbl[4]  = {64'h0000_0056_7800_10A8, 1'b0, 1'b0, 8'd2}; // B into way 1
		tbl[5]  = {64'h0000_0056_7800_10B8, 1'b0, 1'b1, 8'd2};
		tbl[6]  = {64'h0000_0012_3400_08B0, 1'b0, 1'b1, 8'd2}; // touch A
		tbl[7]  = {64'h8000_0000_0000_18B8, 1'b0, 1'b0, 8'd3}; // C evicts B
		tbl[8]  = {64'h0000_0012_3400_08A0, 1'b0, 1'b1, 8'd3};
		tbl[9]  = {64'h0000_0056_7800_10A0, 1'b0, 1'b0, 8'd4}; // B evicts C
		tbl[10] = {64'h0000_0012_3400_08A8, 1'b0, 1'b1, 8'd4};
		tbl[11] = {64'h0000_0000_0000_3FF8, 1'b0, 1'b0, 8'd5};
		tbl[12] = {64'h0000_0000_0000_3FE0, 1'b0, 1'b1, 8'd5};
		tbl[13] = {64'h8000_0000_0000_18A8, 1'b0, 1'b0, 8'd6};
		tbl[14] = {64'h0000_0012_3400_08A8, 1'b1, 1'b0, 8'd7}; // after mid-run reset
		tbl[15] = {64'h0000_0012_3400_08B8, 1'b0, 1'b1, 8'd7};
		tbl[16] = {64'h0000_0000_0000_3FF0, 1'b0, 1'b0, 8'd8};
		tbl[17] = {64'h8000_0000_0000_18B8, 1'b0, 1'b0, 8'd9};
	endtask

	task apply_reset();
		rst_n         = 1'b0;
		cpu_req_valid = 1'b0;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		repeat (2) begin
			@(negedge clk);
			checks++;
			if (cpu_ready !== 1'b0 || mem_req_valid !== 1'b0) begin
				errors++;
				$display("cpu_ready or mem_req_valid is not low right after reset");
			end
		end
	endtask

	task automatic run_row(input int r);
		row_t        t;
		fetch_addr_u a;
		int          cycles;
		t     = tbl[r];
		a.raw = t.addr;
		@(negedge clk);
		cpu_req_valid = 1'b1;
		cpu_req_addr  = t.addr;
		@(negedge clk);
		cycles = 1;
		while (!cpu_ready) begin
			@(negedge clk);
			cycles++;
		end
		cpu_req_valid = 1'b0;
		checks += t.exp_hit ? 3 : 4;
		if (cpu_data_read !== expected_word(a)) begin
			errors++;
			$display("Error: cpu_data_read row %0d got %h expected %h",
				r, cpu_data_read, expected_word(a));
		end
		if (req_count != t.exp_reqs) begin
			errors++;
			$display("Error: req_count row %0d got %h expected %h", r, req_count, t.exp_reqs);
		end
		if (t.exp_hit && cycles != 2) begin
			errors++;
			$display("Row %0d should hit but took %0d cycles instead of 2", r, cycles);
		end else if (!t.exp_hit && cycles <= 2) begin
			errors++;
			$display("Row %0d answered like a hit although a miss was expected", r);
		end
		if (!t.exp_hit && last_req_addr !== {a.f.tag, a.f.index, offset_w'(0)}) begin
			errors++;
			$display("Error: mem_req_addr row %0d got %h expected %h",
				r, last_req_addr, {a.f.tag, a.f.index, offset_w'(0)});
		end
	endtask

	initial begin
		rst_n         = 1'b0;
		cpu_req_valid = 1'b0;
		cpu_req_addr  = '0;
		errors        = 0;
		checks        = 0;
		load_table();
		apply_reset();
		for (int r = 0; r < n_rows; r++) begin
			if (tbl[r].rst_before) begin
				apply_reset();
			end
			run_row(r);
		end
		$display("%0d checks done, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// File: tests/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        mem_req_valid,
	input  logic [63:0] mem_req_addr,
	output logic        mem_ready,
	output logic [63:0] mem_data_read,
	output int          req_count,
	output logic [63:0] last_req_addr
);

	logic        busy;
	int          beat;
	logic [1:0]  stall;  // idle cycles left before the next beat
	logic [15:0] lfsr;

	// 16-bit fibonacci lfsr, taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// beat b of line L: low word of L + 8b, then its inverse
	function automatic logic [63:0] beat_word(input logic [63:0] line, input int b);
		logic [31:0] v;
		v = line[31:0] + 32'(8 * b);
		return {v, ~v};
	endfunction

	task draw_stall();
		lfsr     = lfsr_step(lfsr);
		stall[1] = lfsr[0];
		lfsr     = lfsr_step(lfsr);
		stall[0] = lfsr[0];
	endtask

	initial begin
		mem_ready     = 1'b0;
		mem_data_read = '0;
		req_count     = 0;
		last_req_addr = '0;
		busy          = 1'b0;
		beat          = 0;
		stall         = '0;
		lfsr          = 16'd33;
		forever begin
			@(negedge clk);
			if (!rst_n) begin
				mem_ready = 1'b0;
				busy      = 1'b0;
			end else begin
				if (mem_ready) begin // beat taken on the last rising edge
					mem_ready = 1'b0;
					beat      = beat + 1;
					if (beat == 4) begin
						busy = 1'b0;
					end else begin
						draw_stall();
					end
				end
				if (!busy && mem_req_valid) begin
					busy          = 1'b1;
					beat          = 0;
					req_count     = req_count + 1;
					last_req_addr = mem_req_addr;
					draw_stall();
				end
				if (busy) begin
					if (stall != 0) begin
						stall = stall - 1'b1;
					end else begin
						mem_ready     = 1'b1;
						mem_data_read = beat_word(last_req_addr, beat);
					end
				end
			end
		end
	end

endmodule
